// ==== filelist.f ====
+incdir+rtl
rtl/rvPkg.sv
rtl/exMemIf.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/rvPipelineCore.sv
tests/core_assertions.sv
tests/coreChecker.sv
tests/coreTb.sv

// ==== rtl/exMemIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

interface exMemIf;
    import rvPkg::*;

    logic                   valid;
    logic                   regWrite;
    logic                   memWrite;
    resultSrc_e             resultSrc;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       aluResult;
    logic [`XLEN-1:0]       storeData;

    // execute owns the execute/memory register
    modport exec (output valid, regWrite, memWrite, resultSrc, rd, aluResult, storeData);
    modport mem  (input  valid, regWrite, memWrite, resultSrc, rd, aluResult, storeData);

endinterface

`default_nettype wire

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module executeStage (
    input  wire                        clk,
    input  wire                        rst,
    input  wire rvPkg::decodedInstr_t  decoded,
    input  wire [`XLEN-1:0]            rdData1,
    input  wire [`XLEN-1:0]            rdData2,
    input  wire                        wbRegWrite,
    input  wire [`REG_ADDR_W-1:0]      wbRd,
    input  wire [`XLEN-1:0]            wbData,
    exMemIf.exec                       exMem
);
    import rvPkg::*;

    decodedInstr_t          deInstr;
    logic [`XLEN-1:0]       deRs1Val;
    logic [`XLEN-1:0]       deRs2Val;
    logic [`REG_ADDR_W-1:0] memFwdRd;
    logic [`REG_ADDR_W-1:0] wbFwdRd;
    logic [`XLEN-1:0]       srcA;
    logic [`XLEN-1:0]       fwdRs2;
    logic [`XLEN-1:0]       srcB;
    logic [`XLEN-1:0]       aluOut;

    // newest producer wins, a zero rd never forwards
    function automatic logic [`XLEN-1:0] pickSource(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       regVal,
        input logic [`REG_ADDR_W-1:0] memRd,
        input logic [`XLEN-1:0]       memVal,
        input logic [`REG_ADDR_W-1:0] wbDst,
        input logic [`XLEN-1:0]       wbVal
    );
        if (memRd != '0 && memRd == rs) begin
            return memVal;
        end
        if (wbDst != '0 && wbDst == rs) begin
            return wbVal;
        end
        return regVal;
    endfunction

    // ==================================================
    // decode/execute register
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            deInstr  <= '0;
            deRs1Val <= '0;
            deRs2Val <= '0;
        end else begin
            deInstr  <= decoded;
            deRs1Val <= rdData1;
            deRs2Val <= rdData2;
        end
    end

    // producers that do not write a register look like rd = x0
    assign memFwdRd = (exMem.valid && exMem.regWrite) ? exMem.rd : '0;
    assign wbFwdRd  = wbRegWrite ? wbRd : '0;

    assign srcA   = pickSource(deInstr.rs1, deRs1Val, memFwdRd, exMem.aluResult,
                               wbFwdRd, wbData);
    assign fwdRs2 = pickSource(deInstr.rs2, deRs2Val, memFwdRd, exMem.aluResult,
                               wbFwdRd, wbData);
    assign srcB   = deInstr.aluSrcImm ? deInstr.imm : fwdRs2;

    // ALU
    always_comb begin
        case (deInstr.aluOp)
            ALU_ADD: aluOut = srcA + srcB;
            ALU_SUB: aluOut = srcA - srcB;
            ALU_SLT: aluOut = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_OR:  aluOut = srcA | srcB;
            ALU_AND: aluOut = srcA & srcB;
            default: aluOut = '0;
        endcase
    end

    // ==================================================
    // execute/memory register
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            exMem.valid     <= 1'b0;
            exMem.regWrite  <= 1'b0;
            exMem.memWrite  <= 1'b0;
            exMem.resultSrc <= RES_ALU;
            exMem.rd        <= '0;
            exMem.aluResult <= '0;
            exMem.storeData <= '0;
        end else begin
            exMem.valid     <= deInstr.valid;
            exMem.regWrite  <= deInstr.regWrite;
            exMem.memWrite  <= deInstr.memWrite;
            exMem.resultSrc <= deInstr.resultSrc;
            exMem.rd        <= deInstr.rd;
            exMem.aluResult <= aluOut;
            // store data needs forwarding too
            exMem.storeData <= fwdRs2;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module instrDecoder (
    input  wire [`XLEN-1:0]   instr,
    output rvPkg::decodedInstr_t decoded
);
    import rvPkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    aluOp_e           regOp;
    logic             regOpOk;
    logic             wordAccess;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediate generator, only I and S forms remain
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // lw and sw both use funct3 = 010
    assign wordAccess = (funct3 == 3'b010);

    // ==================================================
    // ALU operation from funct3/funct7
    // ==================================================
    always_comb begin
        regOp   = ALU_ADD;
        regOpOk = (funct7 == 7'b0000000) || (funct3 == 3'b000 && funct7 == 7'b0100000);
        case (funct3)
            3'b000: regOp = funct7[5] ? ALU_SUB : ALU_ADD;
            3'b010: regOp = ALU_SLT;
            3'b110: regOp = ALU_OR;
            3'b111: regOp = ALU_AND;
            default: regOpOk = 1'b0;
        endcase
    end

    // ==================================================
    // control bits from the opcode
    // ==================================================
    always_comb begin
        decoded     = '0;
        decoded.rs1 = instr[19:15];
        decoded.rs2 = instr[24:20];
        case (opcode)
            OP_REG: begin
                decoded.valid    = regOpOk;
                decoded.regWrite = regOpOk;
                decoded.aluOp    = regOp;
                decoded.rd       = instr[11:7];
            end
            OP_IMM: begin
                // addi only
                decoded.valid     = (funct3 == 3'b000);
                decoded.regWrite  = (funct3 == 3'b000);
                decoded.aluSrcImm = 1'b1;
                decoded.imm       = immI;
                decoded.rd        = instr[11:7];
            end
            OP_LOAD: begin
                decoded.valid     = wordAccess;
                decoded.regWrite  = wordAccess;
                decoded.aluSrcImm = 1'b1;
                decoded.resultSrc = RES_MEM;
                decoded.imm       = immI;
                decoded.rd        = instr[11:7];
            end
            OP_STORE: begin
                decoded.valid     = wordAccess;
                decoded.memWrite  = wordAccess;
                decoded.aluSrcImm = 1'b1;
                decoded.imm       = immS;
            end
            // anything else travels down the pipe as a bubble
            default: decoded.valid = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/memWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module memWriteback (
    input  wire                    clk,
    input  wire                    rst,
    exMemIf.mem                    exMem,
    output logic                   wbRegWrite,
    output logic [`REG_ADDR_W-1:0] wbRd,
    output logic [`XLEN-1:0]       wbData
);
    import rvPkg::*;

    logic [`XLEN-1:0]       dmem [`DMEM_WORDS];
    logic [`DMEM_ADDR_W-1:0] wordIdx;
    logic [`XLEN-1:0]       loadWord;
    resultSrc_e             wbResultSrc;
    logic [`XLEN-1:0]       wbAluResult;
    logic [`XLEN-1:0]       wbLoadWord;

    // ==================================================
    // data memory, word addressed
    // ==================================================
    assign wordIdx  = exMem.aluResult[`DMEM_ADDR_W+1:2];
    assign loadWord = dmem[wordIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (exMem.valid && exMem.memWrite) begin
            dmem[wordIdx] <= exMem.storeData;
        end
    end

    // memory/writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite  <= 1'b0;
            wbRd        <= '0;
            wbResultSrc <= RES_ALU;
            wbAluResult <= '0;
            wbLoadWord  <= '0;
        end else begin
            wbRegWrite  <= exMem.valid && exMem.regWrite;
            wbRd        <= exMem.rd;
            wbResultSrc <= exMem.resultSrc;
            wbAluResult <= exMem.aluResult;
            wbLoadWord  <= loadWord;
        end
    end

    assign wbData = (wbResultSrc == RES_MEM) ? wbLoadWord : wbAluResult;

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module regFile (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [`REG_ADDR_W-1:0] rs1,
    input  wire [`REG_ADDR_W-1:0] rs2,
    input  wire                   wbRegWrite,
    input  wire [`REG_ADDR_W-1:0] wbRd,
    input  wire [`XLEN-1:0]       wbData,
    output logic [`XLEN-1:0]      rdData1,
    output logic [`XLEN-1:0]      rdData2
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             writeEn;

    // x0 is never written
    assign writeEn = wbRegWrite && (wbRd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle write shows through to the read ports
    assign rdData1 = (rs1 == '0) ? '0 : (writeEn && wbRd == rs1) ? wbData : regs[rs1];
    assign rdData2 = (rs2 == '0) ? '0 : (writeEn && wbRd == rs2) ? wbData : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/rvPipelineCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rvPipelineCore (
    input  wire                    clk,
    input  wire                    rst,
    output logic [`XLEN-1:0]       fetchAddr,
    input  wire [`XLEN-1:0]        fetchData,
    output logic                   retireValid,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData
);
    import rvPkg::*;

    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       fdInstr;
    logic                   fdValid;
    logic [`XLEN-1:0]       decInstr;
    decodedInstr_t          decoded;
    logic [`XLEN-1:0]       rdData1;
    logic [`XLEN-1:0]       rdData2;
    logic                   wbRegWrite;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic [`XLEN-1:0]       wbData;

    // ==================================================
    // fetch, one word per cycle with no stalls
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc + `PC_STEP;
        end
    end

    assign fetchAddr = pc;

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            fdInstr <= '0;
            fdValid <= 1'b0;
        end else begin
            fdInstr <= fetchData;
            fdValid <= 1'b1;
        end
    end

    // an empty slot decodes as opcode 0, i.e. a bubble
    assign decInstr = fdValid ? fdInstr : '0;

    // decoder and register file read side by side
    instrDecoder i_instrDecoder (
        .instr   (decInstr),
        .decoded (decoded)
    );

    regFile i_regFile (
        .clk        (clk),
        .rst        (rst),
        .rs1        (decInstr[19:15]),
        .rs2        (decInstr[24:20]),
        .wbRegWrite (wbRegWrite),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .rdData1    (rdData1),
        .rdData2    (rdData2)
    );

    exMemIf i_exMemIf ();

    executeStage i_executeStage (
        .clk        (clk),
        .rst        (rst),
        .decoded    (decoded),
        .rdData1    (rdData1),
        .rdData2    (rdData2),
        .wbRegWrite (wbRegWrite),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .exMem      (i_exMemIf.exec)
    );

    memWriteback i_memWriteback (
        .clk        (clk),
        .rst        (rst),
        .exMem      (i_exMemIf.mem),
        .wbRegWrite (wbRegWrite),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    // retire strobe mirrors the register write
    assign retireValid = wbRegWrite && (wbRd != '0);
    assign retireRd    = wbRd;
    assign retireData  = wbData;

endmodule

`default_nettype wire

// ==== rtl/rvPkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rvPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_SLT = 3'd2,
        ALU_OR  = 3'd3,
        ALU_AND = 3'd4
    } aluOp_e;

    // writeback source
    typedef enum logic {
        RES_ALU = 1'b0,
        RES_MEM = 1'b1
    } resultSrc_e;

    // everything execute needs from decode
    typedef struct packed {
        logic                   valid;
        logic                   regWrite;
        logic                   memWrite;
        logic                   aluSrcImm;
        resultSrc_e             resultSrc;
        aluOp_e                 aluOp;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;
    } decodedInstr_t;

endpackage

`default_nettype wire

// ==== rtl/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ==================================================
// datapath widths, fixed by RV32I
// ==================================================
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// ==================================================
// data memory geometry and fetch stride
// ==================================================
`define DMEM_WORDS  256
`define DMEM_ADDR_W 8
`define PC_STEP     4

`endif

// ==== tests/coreChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module coreChecker (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [`XLEN-1:0]       fetchAddr,
    input  wire [`XLEN-1:0]       fetchData,
    input  wire                   retireValid,
    input  wire [`REG_ADDR_W-1:0] retireRd,
    input  wire [`XLEN-1:0]       retireData,
    output int                    pendingCount,
    output int                    errorCount,
    output int                    checkCount
);
    import rvPkg::*;

    logic [`XLEN-1:0]             modelRegs [`NUM_REGS];
    logic [`XLEN-1:0]             modelMem [`DMEM_WORDS];
    logic [`XLEN-1:0]             modelPc;
    logic [`REG_ADDR_W+`XLEN-1:0] expected [$];
    logic [`REG_ADDR_W+`XLEN:0]   step;
    logic [`REG_ADDR_W+`XLEN-1:0] head;
    int                           errors = 0;
    int                           checks = 0;

    // ==================================================
    // sequential ISA model, returns {writes, rd, value}
    // ==================================================
    function automatic logic [`REG_ADDR_W+`XLEN:0] refStep(input logic [`XLEN-1:0] instr);
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       a;
        logic [`XLEN-1:0]       b;
        logic [`XLEN-1:0]       immI;
        logic [`XLEN-1:0]       immS;
        logic [`XLEN-1:0]       value;
        logic                   writes;
        logic                   isWord;
        rd     = instr[11:7];
        a      = modelRegs[instr[19:15]];
        b      = modelRegs[instr[24:20]];
        immI   = {{20{instr[31]}}, instr[31:20]};
        immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        isWord = (instr[14:12] == 3'b010);
        writes = 1'b0;
        value  = '0;
        case (instr[6:0])
            OP_REG: begin
                writes = 1'b1;
                case ({instr[31:25], instr[14:12]})
                    10'b0000000_000: value = a + b;
                    10'b0100000_000: value = a - b;
                    10'b0000000_010: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    10'b0000000_110: value = a | b;
                    10'b0000000_111: value = a & b;
                    default:         writes = 1'b0;
                endcase
            end
            OP_IMM: begin
                writes = (instr[14:12] == 3'b000);
                value  = a + immI;
            end
            OP_LOAD: begin
                writes = isWord;
                value  = modelMem[((a + immI) >> 2) % `DMEM_WORDS];
            end
            OP_STORE: begin
                if (isWord) begin
                    modelMem[((a + immS) >> 2) % `DMEM_WORDS] = b;
                end
            end
            default: writes = 1'b0;
        endcase
        // x0 stays zero and never retires
        writes = writes && (rd != '0);
        if (writes) begin
            modelRegs[rd] = value;
        end
        return {writes, rd, value};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                modelRegs[i] = '0;
            end
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                modelMem[i] = '0;
            end
            modelPc = '0;
            expected.delete();
        end else begin
            // retires must come in program order
            if (retireValid) begin
                if (expected.size() == 0) begin
                    $display("retire of x%0d arrived with no register write pending", retireRd);
                    errors++;
                end else begin
                    head = expected.pop_front();
                    checks++;
                    if (retireRd !== head[`XLEN +: `REG_ADDR_W]) begin
                        $display("[FAIL] retireRd: expected %h, got %h",
                                 head[`XLEN +: `REG_ADDR_W], retireRd);
                        errors++;
                    end
                    if (retireData !== head[`XLEN-1:0]) begin
                        $display("[FAIL] retireData: expected %h, got %h",
                                 head[`XLEN-1:0], retireData);
                        errors++;
                    end
                end
            end
            if (fetchAddr !== modelPc) begin
                $display("[FAIL] fetchAddr: expected %h, got %h", modelPc, fetchAddr);
                errors++;
            end
            modelPc = modelPc + `PC_STEP;
            step = refStep(fetchData);
            if (step[`REG_ADDR_W+`XLEN]) begin
                expected.push_back(step[`REG_ADDR_W+`XLEN-1:0]);
            end
        end
        pendingCount <= expected.size();
        errorCount   <= errors;
        checkCount   <= checks;
    end

endmodule

`default_nettype wire

// ==== tests/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module coreTb;
    import rvPkg::*;

    localparam int              PROG_WORDS = 64;
    localparam int              WAIT_LIMIT = 400;
    localparam logic [`XLEN-1:0] NOP       = 32'h0000_0013;

    logic                   clk;
    logic                   rst;
    logic [`XLEN-1:0]       fetchAddr;
    logic [`XLEN-1:0]       fetchData;
    logic                   retireValid;
    logic [`REG_ADDR_W-1:0] retireRd;
    logic [`XLEN-1:0]       retireData;
    int                     pendingCount;
    int                     errorCount;
    int                     checkCount;

    logic [`XLEN-1:0] progMem [PROG_WORDS];
    int               progLen = 0;
    integer           seed = 32'h7885;
    int               testsRun = 0;
    int               testsFailed = 0;
    int               timeouts = 0;
    int               failsBefore = 0;

    // words past the loaded program read as nop
    assign fetchData = (fetchAddr[`XLEN-1:2] < progLen) ? progMem[fetchAddr[`XLEN-1:2]] : NOP;

    rvPipelineCore i_rvPipelineCore (
        .clk         (clk),
        .rst         (rst),
        .fetchAddr   (fetchAddr),
        .fetchData   (fetchData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    coreChecker i_coreChecker (
        .clk          (clk),
        .rst          (rst),
        .fetchAddr    (fetchAddr),
        .fetchData    (fetchData),
        .retireValid  (retireValid),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .pendingCount (pendingCount),
        .errorCount   (errorCount),
        .checkCount   (checkCount)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int totalFails();
        return errorCount + timeouts + i_rvPipelineCore.i_coreAssertions.failCount;
    endfunction

    // ==================================================
    // instruction encoders
    // ==================================================
    task automatic emit(input logic [`XLEN-1:0] word);
        progMem[progLen] = word;
        progLen++;
    endtask

    task automatic emitAlu(input aluOp_e op, input int rd, input int rs1, input int rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (op == ALU_SUB) ? 7'b0100000 : 7'b0000000;
        case (op)
            ALU_SLT: f3 = 3'b010;
            ALU_OR:  f3 = 3'b110;
            ALU_AND: f3 = 3'b111;
            default: f3 = 3'b000;
        endcase
        emit({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG});
    endtask

    task automatic emitAddi(input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], 3'b000, rd[4:0], OP_IMM});
    endtask

    task automatic emitLw(input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], 3'b010, rd[4:0], OP_LOAD});
    endtask

    task automatic emitSw(input int rs2, input int rs1, input int imm);
        emit({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE});
    endtask

    // no register is read right after a load writes it
    task automatic emitRandom(input int count);
        int kind;
        int rd;
        int rs1;
        int rs2;
        int lastLoad;
        lastLoad = 0;
        for (int i = 0; i < count; i++) begin
            kind = $unsigned($random(seed)) % 8;
            rd   = $unsigned($random(seed)) % 8;
            rs1  = $unsigned($random(seed)) % 8;
            rs2  = $unsigned($random(seed)) % 8;
            if (lastLoad != 0 && rs1 == lastLoad) begin
                rs1 = (rs1 + 1) % 8;
            end
            if (lastLoad != 0 && rs2 == lastLoad) begin
                rs2 = (rs2 + 1) % 8;
            end
            case (kind)
                5:       emitAddi(rd, rs1, $random(seed) % 2048);
                6:       emitLw(rd, 0, ($unsigned($random(seed)) % 16) * 4);
                7:       emitSw(rs2, 0, ($unsigned($random(seed)) % 16) * 4);
                default: emitAlu(aluOp_e'(kind), rd, rs1, rs2);
            endcase
            lastLoad = (kind == 6) ? rd : 0;
        end
    endtask

    // ==================================================
    // test sequencing
    // ==================================================
    task automatic beginTest();
        @(posedge clk);
        rst <= 1'b1;
        failsBefore = totalFails();
        // program is reloaded while the core sits in reset
        @(negedge clk);
        progLen = 0;
    endtask

    task automatic runProgram(input string name);
        int waited;
        int fails;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        // whole program fetched and every write retired
        while ((fetchAddr < progLen * `PC_STEP || pendingCount != 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (fetchAddr < progLen * `PC_STEP || pendingCount != 0) begin
            $display("test %0d %s: retires did not arrive within %0d cycles",
                     testsRun + 1, name, WAIT_LIMIT);
            timeouts++;
        end
        testsRun++;
        fails = totalFails() - failsBefore;
        if (fails == 0) begin
            $display("test %0d %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", testsRun, name, fails);
        end
    endtask

    initial begin
        rst = 1'b1;

        beginTest();
        emitAddi(1, 0, 25);
        emitAddi(2, 0, -7);
        emitAlu(ALU_ADD, 3, 1, 2);
        emitAlu(ALU_SUB, 4, 1, 2);
        emitAlu(ALU_SLT, 5, 2, 1);
        emitAlu(ALU_SLT, 6, 1, 2);
        emitAddi(7, 0, -20);
        emitAlu(ALU_SLT, 8, 7, 2);
        emitAlu(ALU_OR, 9, 1, 2);
        emitAlu(ALU_AND, 10, 1, 2);
        runProgram("alu operations");

        // distance 1 and 2 where the newer x4 must win
        beginTest();
        emitAddi(1, 0, 5);
        emitAlu(ALU_ADD, 2, 1, 1);
        emitAlu(ALU_SUB, 3, 2, 1);
        emitAlu(ALU_OR, 4, 3, 2);
        emitAddi(4, 4, 3);
        emitAddi(4, 4, -9);
        emitAlu(ALU_AND, 5, 4, 3);
        runProgram("forwarding");

        beginTest();
        emitAddi(1, 0, 291);
        emitAddi(2, 0, 64);
        emitSw(1, 2, 8);
        emitSw(2, 0, 0);
        emitLw(3, 0, 72);
        emitLw(4, 0, 0);
        emitLw(5, 0, 40);
        emitAddi(6, 0, 1);
        emitAlu(ALU_ADD, 7, 3, 4);
        emitAlu(ALU_ADD, 8, 5, 6);
        runProgram("memory round trip");

        beginTest();
        emitAddi(1, 0, 9);
        emitAddi(0, 1, 3);
        emitAlu(ALU_ADD, 0, 1, 1);
        emitAlu(ALU_ADD, 2, 0, 1);
        emitAlu(ALU_OR, 3, 0, 0);
        runProgram("x0 writes");

        for (int n = 0; n < 3; n++) begin
            beginTest();
            emitRandom(48);
            runProgram("random program");
        end

        $display("%0d tests run, %0d failed, %0d retires checked, %0d errors",
                 testsRun, testsFailed, checkCount, totalFails());
        if (testsFailed == 0 && totalFails() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/core_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module coreAssertions (
    input wire                   clk,
    input wire                   rst,
    input wire [`XLEN-1:0]       fetchAddr,
    input wire [`XLEN-1:0]       fetchData,
    input wire                   retireValid,
    input wire [`REG_ADDR_W-1:0] retireRd
);

    // assertion failures so far
    int failCount = 0;

    // a retire never names x0 and carries the rd fetched four cycles earlier
    retireRdNonZero: assert property (@(posedge clk) disable iff (rst)
        retireValid |-> (retireRd != '0 && retireRd == $past(fetchData[11:7], 4)))
        else begin
            failCount++;
            $error("retire strobe carries x0 or the wrong destination register");
        end

    // pipeline is empty right after reset
    retireQuietAfterReset: assert property (@(posedge clk) rst |=> !retireValid)
        else begin
            failCount++;
            $error("retire strobe in the cycle after reset");
        end

    fetchStride: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (fetchAddr == $past(fetchAddr) + `PC_STEP))
        else begin
            failCount++;
            $error("fetch address did not advance by one word");
        end

endmodule

bind rvPipelineCore coreAssertions i_coreAssertions (
    .clk         (clk),
    .rst         (rst),
    .fetchAddr   (fetchAddr),
    .fetchData   (fetchData),
    .retireValid (retireValid),
    .retireRd    (retireRd)
);

`default_nettype wire
